// File: src/rs_dispatch_pkg.sv
package rs_dispatch_pkg;

    typedef logic [31:0] word_t;
    typedef logic [7:0]  preg_t;
    typedef logic [6:0]  opcode_t;
    typedef logic [2:0]  funct3_t;
    typedef logic [6:0]  funct7_t;
    typedef logic [3:0]  alu_op_t;
    typedef logic [2:0]  occ_t;
    typedef logic [2:0]  unit_mask_t;     // Bit 0 add, bit 1 mul, bit 2 div

    localparam int RS_DEPTH = 4;

    localparam int UNIT_ADD = 0;
    localparam int UNIT_MUL = 1;
    localparam int UNIT_DIV = 2;

    localparam opcode_t OPCODE_BUBBLE = 7'b0000000;
    localparam opcode_t OPCODE_OP     = 7'b0110011;   // R-type
    localparam funct7_t FUNCT7_MULDIV = 7'b0000001;   // M extension

    localparam funct3_t FUNCT3_MUL = 3'd0;
    localparam funct3_t FUNCT3_DIV = 3'd4;
    localparam funct3_t FUNCT3_REM = 3'd6;

    // APB register map
    localparam word_t REG_ENABLE  = 32'h00;
    localparam word_t REG_CNT_ADD = 32'h04;
    localparam word_t REG_CNT_MUL = 32'h08;
    localparam word_t REG_CNT_DIV = 32'h0C;
    localparam word_t REG_STATUS  = 32'h10;

    typedef struct packed {
        logic    mem_to_reg;
        logic    mem_read;
        logic    mem_write;
        alu_op_t alu_op;
        logic    alu_src1;
        logic    alu_src2;
        logic    jump;
        logic    branch;
    } ctrl_t;

    typedef struct packed {
        opcode_t    opcode;
        funct3_t    funct3;
        funct7_t    funct7;
        word_t      pc;
        word_t      operand1;
        word_t      operand2;
        preg_t      src1_preg;
        preg_t      src2_preg;
        logic [1:0] src_ready;   // Bit 0 operand1, bit 1 operand2
        word_t      immediate;
        preg_t      rd_preg;
        word_t      inst_num;
        ctrl_t      ctrl;
        logic       pred_taken;
        logic       pred_hit;
    } dispatch_t;

    typedef struct packed {
        logic  valid;
        preg_t preg;
        word_t value;
    } cdb_t;

endpackage

// File: src/rs_dispatch_router.sv
`timescale 1ns/100ps

module rs_dispatch_router (
    input  logic                      in_valid,
    input  rs_dispatch_pkg::dispatch_t in_inst,
    output logic                      in_ready,

    input  rs_dispatch_pkg::unit_mask_t enable,
    input  rs_dispatch_pkg::unit_mask_t full,

    output rs_dispatch_pkg::unit_mask_t push,
    output rs_dispatch_pkg::dispatch_t  push_inst,
    output rs_dispatch_pkg::unit_mask_t dispatch_fire
);

    rs_dispatch_pkg::unit_mask_t target;
    rs_dispatch_pkg::unit_mask_t open_units;
    logic                        is_bubble;
    logic                        is_muldiv;

    assign is_bubble = (in_inst.opcode == rs_dispatch_pkg::OPCODE_BUBBLE);
    assign is_muldiv = (in_inst.opcode == rs_dispatch_pkg::OPCODE_OP) &&
                       (in_inst.funct7 == rs_dispatch_pkg::FUNCT7_MULDIV);

    // Unit class, one-hot
    always_comb begin
        target = '0;
        if (is_muldiv) begin
            case (in_inst.funct3)
                rs_dispatch_pkg::FUNCT3_MUL: begin
                    target[rs_dispatch_pkg::UNIT_MUL] = 1'b1;
                end
                rs_dispatch_pkg::FUNCT3_DIV,
                rs_dispatch_pkg::FUNCT3_REM: begin
                    target[rs_dispatch_pkg::UNIT_DIV] = 1'b1;
                end
                default: begin
                    target[rs_dispatch_pkg::UNIT_ADD] = 1'b1;   // MULH, DIVU and the rest
                end
            endcase
        end else begin
            target[rs_dispatch_pkg::UNIT_ADD] = 1'b1;
        end
    end

    assign open_units = enable & ~full;

    // Bubbles are swallowed here and never reach a station
    assign in_ready = is_bubble || (|(target & open_units));

    always_comb begin
        push = '0;
        if (in_valid && !is_bubble) begin
            push = target & open_units;
        end
    end

    assign push_inst     = in_inst;   // Shared by all three stations
    assign dispatch_fire = push;

endmodule

// File: src/rs_station.sv
`timescale 1ns/100ps

module rs_station (
    input  logic                       clk,
    input  logic                       reset,

    input  logic                       push,
    input  rs_dispatch_pkg::dispatch_t push_inst,
    output logic                       full,
    output rs_dispatch_pkg::occ_t      occupancy,

    input  rs_dispatch_pkg::cdb_t      cdb,

    output logic                       issue_valid,
    output rs_dispatch_pkg::dispatch_t issue,
    input  logic                       issue_ready
);

    rs_dispatch_pkg::dispatch_t ent_q    [rs_dispatch_pkg::RS_DEPTH];
    rs_dispatch_pkg::dispatch_t ent_wake [rs_dispatch_pkg::RS_DEPTH];
    rs_dispatch_pkg::dispatch_t ent_n    [rs_dispatch_pkg::RS_DEPTH];
    logic [rs_dispatch_pkg::RS_DEPTH-1:0] vld_q;
    logic [rs_dispatch_pkg::RS_DEPTH-1:0] vld_n;

    logic [$clog2(rs_dispatch_pkg::RS_DEPTH)-1:0] sel;
    logic [$clog2(rs_dispatch_pkg::RS_DEPTH)-1:0] lock_idx_q;
    logic [$clog2(rs_dispatch_pkg::RS_DEPTH)-1:0] push_idx;
    logic                                         lock_q;
    logic                                         fire;

    // Capture a matching CDB result into a waiting operand
    function automatic rs_dispatch_pkg::dispatch_t wake(
        input rs_dispatch_pkg::dispatch_t e,
        input rs_dispatch_pkg::cdb_t      c
    );
        rs_dispatch_pkg::dispatch_t w;
        w = e;
        if (c.valid && !e.src_ready[0] && e.src1_preg == c.preg) begin
            w.operand1     = c.value;
            w.src_ready[0] = 1'b1;
        end
        if (c.valid && !e.src_ready[1] && e.src2_preg == c.preg) begin
            w.operand2     = c.value;
            w.src_ready[1] = 1'b1;
        end
        return w;
    endfunction

    // Oldest ready entry, or the one already offered while stalled
    always_comb begin
        sel         = '0;
        issue_valid = 1'b0;
        if (lock_q) begin
            sel         = lock_idx_q;
            issue_valid = 1'b1;
        end else begin
            for (int i = rs_dispatch_pkg::RS_DEPTH - 1; i >= 0; i--) begin
                if (vld_q[i] && (&ent_q[i].src_ready)) begin
                    sel         = i[$bits(sel)-1:0];
                    issue_valid = 1'b1;
                end
            end
        end
    end

    assign issue = ent_q[sel];
    assign fire  = issue_valid && issue_ready;

    always_comb begin
        occupancy = '0;
        for (int i = 0; i < rs_dispatch_pkg::RS_DEPTH; i++) begin
            occupancy = occupancy + rs_dispatch_pkg::occ_t'(vld_q[i]);
        end
    end

    assign full = &vld_q;

    // Wakeup, compaction above the issued slot, then push into the first free slot
    always_comb begin : next_state
        int   src;
        logic found;
        for (int i = 0; i < rs_dispatch_pkg::RS_DEPTH; i++) begin
            ent_wake[i] = wake(ent_q[i], cdb);
        end
        for (int i = 0; i < rs_dispatch_pkg::RS_DEPTH; i++) begin
            src = (i < rs_dispatch_pkg::RS_DEPTH - 1) ? i + 1 : i;
            if (fire && i >= int'(sel)) begin
                ent_n[i] = ent_wake[src];
                vld_n[i] = (i < rs_dispatch_pkg::RS_DEPTH - 1) ? vld_q[src] : 1'b0;
            end else begin
                ent_n[i] = ent_wake[i];
                vld_n[i] = vld_q[i];
            end
        end
        found    = 1'b0;
        push_idx = '0;
        for (int i = 0; i < rs_dispatch_pkg::RS_DEPTH; i++) begin
            if (!vld_n[i] && !found) begin
                found    = 1'b1;
                push_idx = i[$bits(push_idx)-1:0];
            end
        end
        if (push) begin
            ent_n[push_idx] = wake(push_inst, cdb);   // Same-cycle CDB counts too
            vld_n[push_idx] = 1'b1;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            vld_q      <= '0;
            lock_q     <= 1'b0;
            lock_idx_q <= '0;
        end else begin
            vld_q      <= vld_n;
            lock_q     <= issue_valid && !issue_ready;
            lock_idx_q <= sel;
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < rs_dispatch_pkg::RS_DEPTH; i++) begin
            ent_q[i] <= ent_n[i];
        end
    end

    a_no_push_full : assert property (
        @(posedge clk) disable iff (reset) push |-> !full
    );

    a_issue_hold : assert property (
        @(posedge clk) disable iff (reset)
        issue_valid && !issue_ready |=> issue_valid && $stable(issue)
    );

endmodule

// File: src/rs_dispatch_regs.sv
`timescale 1ns/100ps

module rs_dispatch_regs (
    input  logic                        clk,
    input  logic                        reset,

    input  logic                        psel,
    input  logic                        penable,
    input  logic                        pwrite,
    input  rs_dispatch_pkg::word_t      paddr,
    input  rs_dispatch_pkg::word_t      pwdata,
    output rs_dispatch_pkg::word_t      prdata,
    output logic                        pready,
    output logic                        pslverr,

    output rs_dispatch_pkg::unit_mask_t enable,
    input  rs_dispatch_pkg::unit_mask_t dispatch_fire,
    input  rs_dispatch_pkg::occ_t       occ_add,
    input  rs_dispatch_pkg::occ_t       occ_mul,
    input  rs_dispatch_pkg::occ_t       occ_div
);

    rs_dispatch_pkg::word_t cnt_q [3];   // Indexed by unit bit position
    rs_dispatch_pkg::word_t status;
    logic                   access;
    logic                   wr;
    logic                   addr_hit;

    // Counter offset for unit i
    function automatic rs_dispatch_pkg::word_t cnt_addr(input int i);
        return rs_dispatch_pkg::REG_CNT_ADD + rs_dispatch_pkg::word_t'(4 * i);
    endfunction

    assign access = psel && penable;
    assign wr     = access && pwrite;

    always_comb begin
        case (paddr)
            rs_dispatch_pkg::REG_ENABLE,
            rs_dispatch_pkg::REG_CNT_ADD,
            rs_dispatch_pkg::REG_CNT_MUL,
            rs_dispatch_pkg::REG_CNT_DIV,
            rs_dispatch_pkg::REG_STATUS:  addr_hit = 1'b1;
            default:                      addr_hit = 1'b0;
        endcase
    end

    assign pready  = 1'b1;                // No wait states
    assign pslverr = access && !addr_hit;

    assign status = {21'b0, occ_div, 1'b0, occ_mul, 1'b0, occ_add};

    always_comb begin
        case (paddr)
            rs_dispatch_pkg::REG_ENABLE:  prdata = {29'b0, enable};
            rs_dispatch_pkg::REG_CNT_ADD: prdata = cnt_q[rs_dispatch_pkg::UNIT_ADD];
            rs_dispatch_pkg::REG_CNT_MUL: prdata = cnt_q[rs_dispatch_pkg::UNIT_MUL];
            rs_dispatch_pkg::REG_CNT_DIV: prdata = cnt_q[rs_dispatch_pkg::UNIT_DIV];
            rs_dispatch_pkg::REG_STATUS:  prdata = status;
            default:                      prdata = '0;
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            enable <= '1;                 // All units on out of reset
        end else if (wr && paddr == rs_dispatch_pkg::REG_ENABLE) begin
            enable <= pwdata[2:0];
        end
    end

    // Any write clears, otherwise count and wrap
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < 3; i++) begin
                cnt_q[i] <= '0;
            end
        end else begin
            for (int i = 0; i < 3; i++) begin
                if (wr && paddr == cnt_addr(i)) begin
                    cnt_q[i] <= '0;
                end else if (dispatch_fire[i]) begin
                    cnt_q[i] <= cnt_q[i] + 32'd1;
                end
            end
        end
    end

    a_penable_psel : assert property (
        @(posedge clk) disable iff (reset) penable |-> psel
    );

endmodule

// File: src/rs_dispatch_top.sv
`timescale 1ns/100ps

module rs_dispatch_top (
    input  logic                       clk,
    input  logic                       reset,

    input  logic                       in_valid,
    input  rs_dispatch_pkg::dispatch_t in_inst,
    output logic                       in_ready,

    input  rs_dispatch_pkg::cdb_t      cdb,

    output logic                       add_issue_valid,
    output rs_dispatch_pkg::dispatch_t add_issue,
    input  logic                       add_issue_ready,
    output logic                       mul_issue_valid,
    output rs_dispatch_pkg::dispatch_t mul_issue,
    input  logic                       mul_issue_ready,
    output logic                       div_issue_valid,
    output rs_dispatch_pkg::dispatch_t div_issue,
    input  logic                       div_issue_ready,

    input  logic                       psel,
    input  logic                       penable,
    input  logic                       pwrite,
    input  rs_dispatch_pkg::word_t     paddr,
    input  rs_dispatch_pkg::word_t     pwdata,
    output rs_dispatch_pkg::word_t     prdata,
    output logic                       pready,
    output logic                       pslverr
);

    rs_dispatch_pkg::unit_mask_t enable;
    rs_dispatch_pkg::unit_mask_t full;
    rs_dispatch_pkg::unit_mask_t push;
    rs_dispatch_pkg::unit_mask_t dispatch_fire;
    rs_dispatch_pkg::dispatch_t  push_inst;
    rs_dispatch_pkg::occ_t       occ_add;
    rs_dispatch_pkg::occ_t       occ_mul;
    rs_dispatch_pkg::occ_t       occ_div;

    rs_dispatch_router u_router (
        .in_valid      (in_valid),
        .in_inst       (in_inst),
        .in_ready      (in_ready),
        .enable        (enable),
        .full          (full),
        .push          (push),
        .push_inst     (push_inst),
        .dispatch_fire (dispatch_fire)
    );

    rs_station u_add_rs (
        .clk         (clk),
        .reset       (reset),
        .push        (push[rs_dispatch_pkg::UNIT_ADD]),
        .push_inst   (push_inst),
        .full        (full[rs_dispatch_pkg::UNIT_ADD]),
        .occupancy   (occ_add),
        .cdb         (cdb),
        .issue_valid (add_issue_valid),
        .issue       (add_issue),
        .issue_ready (add_issue_ready)
    );

    rs_station u_mul_rs (
        .clk         (clk),
        .reset       (reset),
        .push        (push[rs_dispatch_pkg::UNIT_MUL]),
        .push_inst   (push_inst),
        .full        (full[rs_dispatch_pkg::UNIT_MUL]),
        .occupancy   (occ_mul),
        .cdb         (cdb),
        .issue_valid (mul_issue_valid),
        .issue       (mul_issue),
        .issue_ready (mul_issue_ready)
    );

    rs_station u_div_rs (
        .clk         (clk),
        .reset       (reset),
        .push        (push[rs_dispatch_pkg::UNIT_DIV]),
        .push_inst   (push_inst),
        .full        (full[rs_dispatch_pkg::UNIT_DIV]),
        .occupancy   (occ_div),
        .cdb         (cdb),
        .issue_valid (div_issue_valid),
        .issue       (div_issue),
        .issue_ready (div_issue_ready)
    );

    rs_dispatch_regs u_regs (
        .clk           (clk),
        .reset         (reset),
        .psel          (psel),
        .penable       (penable),
        .pwrite        (pwrite),
        .paddr         (paddr),
        .pwdata        (pwdata),
        .prdata        (prdata),
        .pready        (pready),
        .pslverr       (pslverr),
        .enable        (enable),
        .dispatch_fire (dispatch_fire),
        .occ_add       (occ_add),
        .occ_mul       (occ_mul),
        .occ_div       (occ_div)
    );

endmodule

// File: tb/tb_rs_dispatch.sv
`timescale 1ns/100ps

module tb_rs_dispatch;

    localparam time DRIVE_DELAY    = 2;
    localparam int  ROUTING_CYCLES = 60 * 3 + 20;
    localparam int  WAKEUP_CYCLES  = 60;
    localparam int  BP_CYCLES      = 60;
    localparam int  ENABLE_CYCLES  = 50;
    localparam int  COUNTER_CYCLES = 40;
    localparam int  BADADDR_CYCLES = 20;
    localparam int  TIMEOUT_CYCLES = 4 + ROUTING_CYCLES + WAKEUP_CYCLES + BP_CYCLES +
                                     ENABLE_CYCLES + COUNTER_CYCLES + BADADDR_CYCLES + 200;

    logic clk;
    logic reset;
    logic in_valid;
    logic in_ready;
    logic add_issue_valid;
    logic add_issue_ready;
    logic mul_issue_valid;
    logic mul_issue_ready;
    logic div_issue_valid;
    logic div_issue_ready;
    logic psel;
    logic penable;
    logic pwrite;
    logic pready;
    logic pslverr;
    rs_dispatch_pkg::dispatch_t in_inst;
    rs_dispatch_pkg::dispatch_t add_issue;
    rs_dispatch_pkg::dispatch_t mul_issue;
    rs_dispatch_pkg::dispatch_t div_issue;
    rs_dispatch_pkg::cdb_t      cdb;
    rs_dispatch_pkg::word_t     paddr;
    rs_dispatch_pkg::word_t     pwdata;
    rs_dispatch_pkg::word_t     prdata;

    rs_dispatch_pkg::dispatch_t exp_q [3][$];   // Expected issue order per unit
    int                         tally [3];
    int                         checks;
    int                         errors;
    int                         test_err0;
    int                         cycles;
    int                         inst_seq;
    string                      test_name;
    rs_dispatch_pkg::funct3_t   other_f3 [5] = '{3'd1, 3'd2, 3'd3, 3'd5, 3'd7};

    rs_dispatch_top u_rs_dispatch_top (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Unit class by the routing rule, zero for a bubble
    function automatic rs_dispatch_pkg::unit_mask_t expected_unit(
        input rs_dispatch_pkg::dispatch_t inst
    );
        rs_dispatch_pkg::unit_mask_t u;
        u = 3'b001;
        if (inst.opcode == rs_dispatch_pkg::OPCODE_BUBBLE) begin
            u = 3'b000;
        end else if (inst.opcode == rs_dispatch_pkg::OPCODE_OP &&
                     inst.funct7 == rs_dispatch_pkg::FUNCT7_MULDIV) begin
            if (inst.funct3 == rs_dispatch_pkg::FUNCT3_MUL) begin
                u = 3'b010;
            end else if (inst.funct3 == rs_dispatch_pkg::FUNCT3_DIV ||
                         inst.funct3 == rs_dispatch_pkg::FUNCT3_REM) begin
                u = 3'b100;
            end
        end
        return u;
    endfunction

    function automatic rs_dispatch_pkg::word_t expected_status();
        rs_dispatch_pkg::word_t s;
        s = '0;
        s[2:0]  = 3'(exp_q[0].size());
        s[6:4]  = 3'(exp_q[1].size());
        s[10:8] = 3'(exp_q[2].size());
        return s;
    endfunction

    function automatic rs_dispatch_pkg::dispatch_t make_inst(
        input rs_dispatch_pkg::opcode_t op,
        input rs_dispatch_pkg::funct3_t f3,
        input rs_dispatch_pkg::funct7_t f7
    );
        rs_dispatch_pkg::dispatch_t d;
        d            = '0;
        d.opcode     = op;
        d.funct3     = f3;
        d.funct7     = f7;
        d.pc         = $urandom;
        d.operand1   = $urandom;
        d.operand2   = $urandom;
        d.src1_preg  = 8'($urandom);
        d.src2_preg  = 8'($urandom);
        d.src_ready  = 2'b11;
        d.immediate  = $urandom;
        d.rd_preg    = 8'($urandom);
        d.inst_num   = inst_seq;
        d.ctrl       = 11'($urandom_range(0, 2047));
        d.pred_taken = 1'($urandom);
        d.pred_hit   = 1'($urandom);
        inst_seq++;
        return d;
    endfunction

    task automatic check_issue(input string what, input rs_dispatch_pkg::dispatch_t exp,
                               input rs_dispatch_pkg::dispatch_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("CHECK FAILED %s %s: expected %h actual %h", test_name, what, exp, act);
        end
    endtask

    task automatic check_unit(input string what, input rs_dispatch_pkg::unit_mask_t exp,
                              input rs_dispatch_pkg::unit_mask_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("CHECK FAILED %s %s: expected %b actual %b", test_name, what, exp, act);
        end
    endtask

    task automatic check_word(input string what, input rs_dispatch_pkg::word_t exp,
                              input rs_dispatch_pkg::word_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("CHECK FAILED %s %s: expected %h actual %h", test_name, what, exp, act);
        end
    endtask

    task automatic compare_issue(input int u, input rs_dispatch_pkg::dispatch_t act);
        if (exp_q[u].size() == 0) begin
            errors++;
            $display("Unit %0d issued inst_num %0d with nothing pending", u, act.inst_num);
        end else begin
            check_issue($sformatf("issue unit %0d", u), exp_q[u].pop_front(), act);
        end
    endtask

    // Handshakes are sampled mid-cycle and take effect at the next rising edge
    always @(negedge clk) begin
        if (!reset) begin
            if (add_issue_valid && add_issue_ready) begin
                compare_issue(rs_dispatch_pkg::UNIT_ADD, add_issue);
            end
            if (mul_issue_valid && mul_issue_ready) begin
                compare_issue(rs_dispatch_pkg::UNIT_MUL, mul_issue);
            end
            if (div_issue_valid && div_issue_ready) begin
                compare_issue(rs_dispatch_pkg::UNIT_DIV, div_issue);
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > TIMEOUT_CYCLES) begin
            $display("Timeout: run stopped after %0d cycles", cycles);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    task automatic next_cycle();
        @(posedge clk);
        #DRIVE_DELAY;
    endtask

    task automatic send(input rs_dispatch_pkg::dispatch_t inst,
                        input rs_dispatch_pkg::dispatch_t exp);
        rs_dispatch_pkg::unit_mask_t u;
        logic                        taken;
        u        = expected_unit(inst);
        taken    = 1'b0;
        in_inst  = inst;
        in_valid = 1'b1;
        while (!taken) begin
            @(negedge clk);
            if (in_ready) begin
                taken = 1'b1;
                for (int i = 0; i < 3; i++) begin
                    if (u[i]) begin
                        exp_q[i].push_back(exp);
                        tally[i]++;
                    end
                end
            end
            next_cycle();
        end
        in_valid = 1'b0;
    endtask

    // in_ready follows in_inst alone, so it is probed with in_valid low
    task automatic probe_ready(input rs_dispatch_pkg::dispatch_t inst, input logic exp,
                               input string what);
        in_inst = inst;
        @(negedge clk);
        check_word(what, rs_dispatch_pkg::word_t'(exp), rs_dispatch_pkg::word_t'(in_ready));
        next_cycle();
    endtask

    task automatic check_idle(input string what);
        @(negedge clk);
        check_unit(what, '0, {div_issue_valid, mul_issue_valid, add_issue_valid});
        next_cycle();
    endtask

    task automatic broadcast(input rs_dispatch_pkg::preg_t tag, input rs_dispatch_pkg::word_t v);
        cdb.valid = 1'b1;
        cdb.preg  = tag;
        cdb.value = v;
        next_cycle();
        cdb.valid = 1'b0;
    endtask

    task automatic drain(input rs_dispatch_pkg::unit_mask_t units);
        while ((units[0] && exp_q[0].size() != 0) || (units[1] && exp_q[1].size() != 0) ||
               (units[2] && exp_q[2].size() != 0)) begin
            next_cycle();
        end
    endtask

    // Two-cycle access, pready must already be high in the access phase
    task automatic apb_access(input logic write, input rs_dispatch_pkg::word_t addr,
                              input rs_dispatch_pkg::word_t wdata,
                              output rs_dispatch_pkg::word_t rdata, output logic err);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = write;
        paddr   = addr;
        pwdata  = wdata;
        next_cycle();
        penable = 1'b1;
        @(negedge clk);
        check_word("pready in access phase", 32'h1, rs_dispatch_pkg::word_t'(pready));
        rdata = prdata;
        err   = pslverr;
        next_cycle();
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic start_test(input string name);
        test_name = name;
        test_err0 = errors;
    endtask

    task automatic end_test();
        $display("Test %-12s %s, %0d errors", test_name,
                 (errors == test_err0) ? "passed" : "failed", errors - test_err0);
    endtask

    initial begin
        rs_dispatch_pkg::dispatch_t inst;
        rs_dispatch_pkg::dispatch_t exp;
        rs_dispatch_pkg::word_t     rd;
        rs_dispatch_pkg::word_t     v1;
        rs_dispatch_pkg::word_t     v2;
        logic                       err;
        void'($urandom(22664));
        reset           = 1'b1;
        in_valid        = 1'b0;
        in_inst         = '0;
        cdb             = '0;
        add_issue_ready = 1'b1;
        mul_issue_ready = 1'b1;
        div_issue_ready = 1'b1;
        psel            = 1'b0;
        penable         = 1'b0;
        pwrite          = 1'b0;
        paddr           = '0;
        pwdata          = '0;
        repeat (4) @(posedge clk);
        #DRIVE_DELAY;
        reset = 1'b0;

        start_test("routing");
        for (int n = 0; n < 60; n++) begin
            case ($urandom_range(0, 6))
                0: inst = make_inst(rs_dispatch_pkg::OPCODE_OP, 3'd0, 7'h01);
                1: inst = make_inst(rs_dispatch_pkg::OPCODE_OP, 3'd4, 7'h01);
                2: inst = make_inst(rs_dispatch_pkg::OPCODE_OP, 3'd6, 7'h01);
                3: inst = make_inst(rs_dispatch_pkg::OPCODE_OP, other_f3[$urandom_range(0, 4)],
                                    7'h01);
                4: inst = make_inst(rs_dispatch_pkg::OPCODE_OP, 3'($urandom),
                                    $urandom_range(0, 1) ? 7'h20 : 7'h00);
                5: inst = make_inst(7'($urandom_range(1, 127)), 3'($urandom), 7'($urandom));
                default: inst = make_inst(rs_dispatch_pkg::OPCODE_BUBBLE, 3'($urandom),
                                          7'($urandom));
            endcase
            send(inst, inst);
        end
        drain(3'b111);
        end_test();

        start_test("wakeup");
        v1 = $urandom;
        inst = make_inst(rs_dispatch_pkg::OPCODE_OP, 3'd0, 7'h00);
        inst.src1_preg = 8'h21;
        inst.src2_preg = 8'h21;                   // Already ready and must keep its value
        inst.src_ready = 2'b10;
        exp = inst;
        exp.operand1  = v1;
        exp.src_ready = 2'b11;
        send(inst, exp);
        repeat (2) check_idle("add waits for tag 21");
        broadcast(8'h21, v1);
        drain(3'b111);
        v1 = $urandom;
        v2 = $urandom;
        inst = make_inst(rs_dispatch_pkg::OPCODE_OP, 3'd0, 7'h01);
        inst.src1_preg = 8'h30;
        inst.src2_preg = 8'h31;
        inst.src_ready = 2'b00;
        exp = inst;
        exp.operand1  = v1;
        exp.operand2  = v2;
        exp.src_ready = 2'b11;
        send(inst, exp);
        check_idle("mul waits for both tags");
        broadcast(8'h30, v1);
        check_idle("mul waits for tag 31");
        broadcast(8'h31, v2);
        drain(3'b111);
        v1 = $urandom;
        inst = make_inst(rs_dispatch_pkg::OPCODE_OP, 3'd4, 7'h01);
        inst.src2_preg = 8'h40;
        inst.src_ready = 2'b01;
        exp = inst;
        exp.operand2  = v1;
        exp.src_ready = 2'b11;
        cdb.valid = 1'b1;                         // Same cycle as the push
        cdb.preg  = 8'h40;
        cdb.value = v1;
        send(inst, exp);
        cdb.valid = 1'b0;
        drain(3'b111);
        end_test();

        start_test("backpressure");
        mul_issue_ready = 1'b0;
        for (int n = 0; n < rs_dispatch_pkg::RS_DEPTH; n++) begin
            inst = make_inst(rs_dispatch_pkg::OPCODE_OP, 3'd0, 7'h01);
            send(inst, inst);
        end
        probe_ready(make_inst(rs_dispatch_pkg::OPCODE_OP, 3'd0, 7'h01), 1'b0, "mul in_ready");
        probe_ready(make_inst(rs_dispatch_pkg::OPCODE_OP, 3'd0, 7'h00), 1'b1, "add in_ready");
        for (int n = 0; n < 3; n++) begin
            inst = make_inst(rs_dispatch_pkg::OPCODE_OP, 3'd7, 7'h00);
            send(inst, inst);
        end
        drain(3'b001);
        apb_access(1'b0, rs_dispatch_pkg::REG_STATUS, '0, rd, err);
        check_word("status under stall", expected_status(), rd);
        mul_issue_ready = 1'b1;
        drain(3'b111);
        end_test();

        start_test("enables");
        apb_access(1'b1, rs_dispatch_pkg::REG_ENABLE, 32'h3, rd, err);
        apb_access(1'b0, rs_dispatch_pkg::REG_ENABLE, '0, rd, err);
        check_word("enable readback", 32'h3, rd);
        probe_ready(make_inst(rs_dispatch_pkg::OPCODE_OP, 3'd4, 7'h01), 1'b0, "div blocked");
        probe_ready(make_inst(rs_dispatch_pkg::OPCODE_OP, 3'd6, 7'h01), 1'b0, "rem blocked");
        probe_ready(make_inst(rs_dispatch_pkg::OPCODE_OP, 3'd0, 7'h01), 1'b1, "mul open");
        apb_access(1'b1, rs_dispatch_pkg::REG_ENABLE, 32'h7, rd, err);
        apb_access(1'b0, rs_dispatch_pkg::REG_ENABLE, '0, rd, err);
        check_word("enable readback", 32'h7, rd);
        inst = make_inst(rs_dispatch_pkg::OPCODE_OP, 3'd4, 7'h01);
        send(inst, inst);
        inst = make_inst(rs_dispatch_pkg::OPCODE_OP, 3'd6, 7'h01);
        send(inst, inst);
        drain(3'b111);
        end_test();

        start_test("counters");
        for (int i = 0; i < 3; i++) begin
            apb_access(1'b0, rs_dispatch_pkg::REG_CNT_ADD + 4 * i, '0, rd, err);
            check_word($sformatf("count unit %0d", i), rs_dispatch_pkg::word_t'(tally[i]), rd);
        end
        apb_access(1'b1, rs_dispatch_pkg::REG_CNT_MUL, 32'hFFFF_FFFF, rd, err);
        tally[rs_dispatch_pkg::UNIT_MUL] = 0;
        apb_access(1'b0, rs_dispatch_pkg::REG_CNT_MUL, '0, rd, err);
        check_word("mul count cleared", '0, rd);
        inst = make_inst(rs_dispatch_pkg::OPCODE_OP, 3'd0, 7'h01);
        send(inst, inst);
        drain(3'b111);
        apb_access(1'b0, rs_dispatch_pkg::REG_CNT_MUL, '0, rd, err);
        check_word("mul count after clear", rs_dispatch_pkg::word_t'(tally[1]), rd);
        end_test();

        start_test("bad_address");
        apb_access(1'b0, 32'h14, '0, rd, err);
        check_word("pslverr read 0x14", 32'h1, rs_dispatch_pkg::word_t'(err));
        apb_access(1'b1, 32'h40, 32'h5, rd, err);
        check_word("pslverr write 0x40", 32'h1, rs_dispatch_pkg::word_t'(err));
        apb_access(1'b0, rs_dispatch_pkg::REG_STATUS, '0, rd, err);
        check_word("pslverr mapped read", 32'h0, rs_dispatch_pkg::word_t'(err));
        end_test();

        $display("Summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// File: rs_dispatch.f
src/rs_dispatch_pkg.sv
src/rs_dispatch_router.sv
src/rs_station.sv
src/rs_dispatch_regs.sv
src/rs_dispatch_top.sv
tb/tb_rs_dispatch.sv
